// ==== build.f ====
+incdir+hdl
hdl/md_pkg.sv
hdl/md_in_queue.sv
hdl/md_operand_prep.sv
hdl/md_divider.sv
hdl/md_multiplier.sv
hdl/md_result_stage.sv
hdl/md_unit.sv
dv/md_unit_sva.sv
dv/md_unit_tb.sv

// ==== dv/md_unit_sva.sv ====
// credit and valid protocol checks
`timescale 1ns/1ns
`default_nettype none
`include "md_cfg.svh"

module md_unit_sva (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_credit,
    input logic rsp_valid,
    input logic rsp_credit
);

    int prod_credits;
    int unit_credits;

    // credits on each side as seen from the pins
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_credits <= `MD_IN_DEPTH;
            unit_credits <= `MD_OUT_CREDITS;
        end else begin
            prod_credits <= prod_credits - int'(req_valid) + int'(req_credit);
            unit_credits <= unit_credits - int'(rsp_valid) + int'(rsp_credit);
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!req_credit && !rsp_valid))
        else $error("req_credit or rsp_valid high right after reset");

    a_rsp_has_credit: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (unit_credits > 0))
        else $error("rsp_valid with a zero credit count");

    a_req_has_credit: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (prod_credits > 0))
        else $error("request sent without a credit");

    // the queue never hands back more than it took
    a_req_credit_bound: assert property (@(posedge clk) disable iff (rst)
        prod_credits <= `MD_IN_DEPTH)
        else $error("more input credits returned than spent");

endmodule

bind md_unit md_unit_sva sva0 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit)
);

`default_nettype wire

// ==== dv/md_unit_tb.sv ====
// md_unit testbench
`timescale 1ns/1ns
`default_nettype none
`include "md_cfg.svh"

module md_unit_tb
    import md_pkg::*;
();

    localparam int n_random   = 300;
    localparam int wait_limit = 2000;

    logic    clk;
    logic    rst;
    logic    req_valid;
    md_req_t req;
    logic    req_credit;
    logic    rsp_valid;
    md_rsp_t rsp;
    logic    rsp_credit;

    logic [31:0]          stim_state;
    logic [31:0]          gap_state;
    logic [`MD_TAG_W-1:0] next_tag;
    logic                 hold;
    // {tag, result} in request order
    logic [`MD_TAG_W+31:0] exp_q [$];

    int errors;
    int checks;
    int timeouts;
    int prod_credits;
    int unit_credits;
    int owed;
    int rsp_count;

    md_unit dut0 (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // about one in eight is an edge value
    function automatic logic [31:0] pick_operand();
        stim_state = lcg_step(stim_state);
        if (stim_state[31:29] != 3'd0) begin
            return lcg_step(stim_state ^ 32'h5a5a_0f0f);
        end
        case (stim_state[28:27])
            2'd0:    return 32'd0;
            2'd1:    return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // rv32m rules in 64-bit arithmetic
    function automatic logic [31:0] expected_result(input md_op_e op, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        wide;
        logic               ovf;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ua   = {32'd0, a};
        ub   = {32'd0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        wide = '0;
        case (op)
            op_mul:    wide = sa * sb;
            op_mulh:   wide = (sa * sb) >> 32;
            op_mulhsu: wide = (sa * $signed(ub)) >> 32;
            op_mulhu:  wide = (ua * ub) >> 32;
            op_div: begin
                if (b == 0) begin
                    wide = '1;
                end else if (ovf) begin
                    wide = 64'h8000_0000;
                end else begin
                    wide = sa / sb;
                end
            end
            op_divu:   wide = (b == 0) ? '1 : ua / ub;
            // remainder keeps the dividend's sign
            op_rem: begin
                if (b == 0) begin
                    wide = ua;
                end else if (ovf) begin
                    wide = 64'd0;
                end else begin
                    wide = sa % sb;
                end
            end
            default:   wide = (b == 0) ? ua : ua % ub;
        endcase
        return wide[31:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_request(input md_op_e op, input logic [31:0] a, input logic [31:0] b);
        int waited;
        waited = 0;
        while (prod_credits == 0 && waited < wait_limit) begin
            req_valid = 1'b0;
            idle_cycles(1);
            waited++;
        end
        if (prod_credits == 0) begin
            $display("timed out waiting for a request credit at %0t", $time);
            timeouts++;
        end else begin
            req_valid = 1'b1;
            req       = '{op: op, tag: next_tag, a: a, b: b};
            prod_credits--;
            exp_q.push_back({next_tag, expected_result(op, a, b)});
            next_tag++;
            idle_cycles(1);
            req_valid = 1'b0;
        end
    endtask

    // all responses in and every response credit handed back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed != 0) && waited < wait_limit) begin
            idle_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0 || owed != 0) begin
            $display("timed out with %0d responses still missing", exp_q.size());
            timeouts++;
        end
        idle_cycles(4);
    endtask

    task automatic set_hold(input logic v);
        @(negedge clk);
        hold = v;
        @(posedge clk);
        #1;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        logic [`MD_TAG_W+31:0] e;
        if (!rst) begin
            if (req_credit) begin
                prod_credits++;
            end
            if (rsp_valid) begin
                rsp_count++;
                owed++;
                if (unit_credits == 0) begin
                    $display("response sent at %0t while the unit held no credit", $time);
                    errors++;
                end else begin
                    unit_credits--;
                end
                if (exp_q.size() == 0) begin
                    $display("response at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("rsp.tag", 32'(rsp.tag), 32'(e[`MD_TAG_W+31:32]));
                    check_value("rsp.result", rsp.result, e[31:0]);
                end
            end
            // a credit returned now is usable from the next cycle
            if (rsp_credit) begin
                unit_credits++;
            end
        end
    end

    // consumer returns credits one at a time after random gaps
    initial begin
        int gap;
        gap = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && !hold && owed > 0 && gap == 0) begin
                rsp_credit = 1'b1;
                owed--;
                gap_state = lcg_step(gap_state);
                gap = (gap_state[29:27] == 3'd0) ? 12 : int'(gap_state[31:30]);
            end else begin
                rsp_credit = 1'b0;
                if (gap > 0) begin
                    gap--;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_credit   = 1'b0;
        hold         = 1'b0;
        stim_state   = 32'h2c24;
        gap_state    = 32'h2c24;
        next_tag     = '0;
        errors       = 0;
        checks       = 0;
        timeouts     = 0;
        prod_credits = `MD_IN_DEPTH;
        unit_credits = `MD_OUT_CREDITS;
        owed         = 0;
        rsp_count    = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(2);

        // zero divisor, overflow and sign cases
        send_request(op_div, 32'd1234, 32'd0);
        send_request(op_divu, 32'hdead_beef, 32'd0);
        send_request(op_rem, 32'hffff_f000, 32'd0);
        send_request(op_remu, 32'h1234_5678, 32'd0);
        send_request(op_div, 32'h8000_0000, 32'hffff_ffff);
        send_request(op_rem, 32'h8000_0000, 32'hffff_ffff);
        send_request(op_div, 32'hffff_fff9, 32'd2);
        send_request(op_rem, 32'hffff_fff9, 32'd2);
        send_request(op_rem, 32'd7, 32'hffff_fffe);
        send_request(op_mulh, 32'h8000_0000, 32'h8000_0000);
        send_request(op_mulhsu, 32'hffff_ffff, 32'hffff_ffff);
        send_request(op_mulhu, 32'hffff_ffff, 32'hffff_ffff);
        wait_drain();

        for (int i = 0; i < n_random; i++) begin
            stim_state = lcg_step(stim_state);
            r = stim_state;
            send_request(md_op_e'(r[31:29]), pick_operand(), pick_operand());
            if (r[28:27] == 2'd0) begin
                idle_cycles(int'(r[26:25]));
            end
        end
        wait_drain();

        // withheld credits, buffer and queue fill up
        set_hold(1'b1);
        rsp_count = 0;
        for (int i = 0; i < 2 * `MD_IN_DEPTH; i++) begin
            stim_state = lcg_step(stim_state);
            send_request(md_op_e'(stim_state[31:29]), pick_operand(), pick_operand());
        end
        idle_cycles(300);
        check_value("rsp_count", 32'(rsp_count), `MD_OUT_CREDITS);
        check_value("prod_credits", 32'(prod_credits), 32'd0);
        set_hold(1'b0);
        wait_drain();

        check_value("prod_credits", 32'(prod_credits), `MD_IN_DEPTH);

        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/md_cfg.svh ====
// multiply divide unit configuration
`ifndef MD_CFG_SVH
`define MD_CFG_SVH

// input queue entries, also the producer's starting credits
`define MD_IN_DEPTH 4

// response credits held by the unit after reset
`define MD_OUT_CREDITS 2

// request tag width
`define MD_TAG_W 4

// restoring divider iterations
`define MD_DIV_STEPS 32

`endif

// ==== hdl/md_divider.sv ====
// iterative restoring divider
`timescale 1ns/1ns
`default_nettype none
`include "md_cfg.svh"

module md_divider
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      div_start,
    input  md_issue_t issue,
    output logic      div_done,
    output md_exec_t  div_res
);

    localparam int unsigned steps = `MD_DIV_STEPS;
    localparam int unsigned cnt_w = $clog2(steps + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_shift,
        st_done
    } div_state_e;

    div_state_e           state;
    logic [cnt_w-1:0]     count;
    // {remainder, quotient}
    logic [63:0]          data;
    logic [31:0]          divisor;
    md_op_e               op_q;
    logic [`MD_TAG_W-1:0] tag_q;
    logic                 neg_quot_q;
    logic                 neg_rem_q;
    logic                 neg_prod_q;
    logic                 special_q;

    logic                 div_zero;
    logic                 overflow;
    logic                 accept;
    logic [32:0]          diff;
    logic                 fits;

    assign div_zero = (issue.opnd_b == 32'd0);
    assign overflow = (issue.op inside {op_div, op_rem})
                    && (issue.opnd_a == 32'h8000_0000)
                    && (issue.opnd_b == 32'hffff_ffff);
    assign accept   = (state == st_idle) && div_start;

    // partial remainder shifted left is 33 bits wide.
    // bit 32 of the difference is the borrow
    assign diff = data[63:31] - {1'b0, divisor};
    assign fits = ~diff[32];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (div_start) begin
                        if (div_zero || overflow) begin
                            state <= st_done;
                        end else begin
                            state <= st_shift;
                            count <= cnt_w'(steps);
                        end
                    end
                end
                st_shift: begin
                    count <= count - 1'b1;
                    if (count == cnt_w'(1)) begin
                        state <= st_done;
                    end
                end
                st_done: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= issue.op;
            tag_q      <= issue.tag;
            neg_quot_q <= issue.neg_quot;
            neg_rem_q  <= issue.neg_rem;
            neg_prod_q <= issue.neg_prod;
            special_q  <= div_zero | overflow;
            divisor    <= issue.mag_b;
            if (div_zero) begin
                data <= {issue.opnd_a, 32'hffff_ffff};
            end else if (overflow) begin
                data <= {32'd0, 32'h8000_0000};
            end else begin
                data <= {32'd0, issue.mag_a};
            end
        end else if (state == st_shift) begin
            if (fits) begin
                data <= {diff[31:0], data[30:0], 1'b1};
            end else begin
                data <= {data[62:0], 1'b0};
            end
        end
    end

    assign div_done = (state == st_done);

    always_comb begin
        div_res.op       = op_q;
        div_res.tag      = tag_q;
        div_res.neg_quot = neg_quot_q;
        div_res.neg_rem  = neg_rem_q;
        div_res.neg_prod = neg_prod_q;
        div_res.special  = special_q;
        div_res.val      = data;
    end

endmodule

`default_nettype wire

// ==== hdl/md_in_queue.sv ====
// request input queue
`timescale 1ns/1ns
`default_nettype none
`include "md_cfg.svh"

module md_in_queue
    import md_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid,
    input  md_req_t req,
    output logic    req_credit,
    output logic    head_valid,
    output md_req_t head,
    input  logic    head_take
);

    localparam int unsigned depth = `MD_IN_DEPTH;
    localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int unsigned cnt_w = $clog2(depth + 1);

    md_req_t          mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // wrap for depths that are not a power of two
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // producer only sends with a credit, so the queue never overflows
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (head_take) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({req_valid, head_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per dequeued entry
            req_credit <= head_take;
        end
    end

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/md_multiplier.sv ====
// two-cycle 33x33 signed multiplier
`timescale 1ns/1ns
`default_nettype none

module md_multiplier
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mul_start,
    input  md_issue_t issue,
    output logic      mul_done,
    output md_exec_t  mul_res
);

    logic                 ext_a;
    logic                 ext_b;
    logic                 v1;
    logic                 v2;
    logic signed [32:0]   a_s1;
    logic signed [32:0]   b_s1;
    md_op_e               op_s1;
    logic [`MD_TAG_W-1:0] tag_s1;
    logic                 neg_prod_s1;
    logic signed [65:0]   prod;

    // rs1 signed except mulhu, rs2 signed for mul and mulh only
    assign ext_a = (issue.op != op_mulhu) & issue.opnd_a[31];
    assign ext_b = (issue.op inside {op_mul, op_mulh}) & issue.opnd_b[31];

    assign prod = a_s1 * b_s1;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= mul_start;
            v2 <= v1;
        end
    end

    // operand stage
    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_s1        <= {ext_a, issue.opnd_a};
            b_s1        <= {ext_b, issue.opnd_b};
            op_s1       <= issue.op;
            tag_s1      <= issue.tag;
            neg_prod_s1 <= issue.neg_prod;
        end
    end

    // product stage
    always_ff @(posedge clk) begin
        if (v1) begin
            mul_res.op       <= op_s1;
            mul_res.tag      <= tag_s1;
            mul_res.neg_quot <= 1'b0;
            mul_res.neg_rem  <= 1'b0;
            mul_res.neg_prod <= neg_prod_s1;
            mul_res.special  <= 1'b0;
            mul_res.val      <= prod[63:0];
        end
    end

    assign mul_done = v2;

endmodule

`default_nettype wire

// ==== hdl/md_operand_prep.sv ====
// operand decode and issue
`timescale 1ns/1ns
`default_nettype none

module md_operand_prep
    import md_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      head_valid,
    input  md_req_t   head,
    output logic      head_take,
    input  logic      result_ready,
    input  logic      mul_done,
    input  logic      div_done,
    output md_issue_t issue,
    output logic      mul_start,
    output logic      div_start
);

    logic in_flight;
    logic go;
    logic is_div;
    logic sign_a;
    logic sign_b;
    logic neg_a;
    logic neg_b;

    // which operands are treated as signed
    always_comb begin
        sign_a = 1'b0;
        sign_b = 1'b0;
        case (head.op)
            op_mul, op_mulh, op_div, op_rem: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            // only rs1 signed
            op_mulhsu: sign_a = 1'b1;
            default: ;
        endcase
    end

    assign neg_a  = sign_a & head.a[31];
    assign neg_b  = sign_b & head.b[31];
    assign is_div = head.op inside {op_div, op_divu, op_rem, op_remu};

    always_comb begin
        issue.op       = head.op;
        issue.tag      = head.tag;
        issue.mag_a    = neg_a ? (~head.a + 32'd1) : head.a;
        issue.mag_b    = neg_b ? (~head.b + 32'd1) : head.b;
        issue.opnd_a   = head.a;
        issue.opnd_b   = head.b;
        issue.neg_quot = neg_a ^ neg_b;
        // remainder follows the dividend
        issue.neg_rem  = neg_a;
        issue.neg_prod = neg_a ^ neg_b;
    end

    // single operation in flight, and only with a free result slot
    assign go        = head_valid & ~in_flight & result_ready;
    assign head_take = go;
    assign mul_start = go & ~is_div;
    assign div_start = go & is_div;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (go) begin
            in_flight <= 1'b1;
        end else if (mul_done || div_done) begin
            in_flight <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/md_pkg.sv ====
// multiply divide unit types
`default_nettype none
`include "md_cfg.svh"

package md_pkg;

    // coded like funct3
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } md_op_e;

    typedef struct packed {
        md_op_e                 op;
        logic [`MD_TAG_W-1:0]   tag;
        logic [31:0]            a;
        logic [31:0]            b;
    } md_req_t;

    // magnitudes for the divider, original operands for mul and special cases
    typedef struct packed {
        md_op_e                 op;
        logic [`MD_TAG_W-1:0]   tag;
        logic [31:0]            mag_a;
        logic [31:0]            mag_b;
        logic [31:0]            opnd_a;
        logic [31:0]            opnd_b;
        logic                   neg_quot;
        logic                   neg_rem;
        logic                   neg_prod;
    } md_issue_t;

    // val is the product, or {remainder, quotient} for division
    typedef struct packed {
        md_op_e                 op;
        logic [`MD_TAG_W-1:0]   tag;
        logic                   neg_quot;
        logic                   neg_rem;
        logic                   neg_prod;
        logic                   special;
        logic [63:0]            val;
    } md_exec_t;

    typedef struct packed {
        logic [`MD_TAG_W-1:0]   tag;
        logic [31:0]            result;
    } md_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/md_result_stage.sv ====
// result fixup and response buffer
`timescale 1ns/1ns
`default_nettype none
`include "md_cfg.svh"

module md_result_stage
    import md_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     mul_done,
    input  md_exec_t mul_res,
    input  logic     div_done,
    input  md_exec_t div_res,
    output logic     result_ready,
    output logic     rsp_valid,
    output md_rsp_t  rsp,
    input  logic     rsp_credit
);

    localparam int unsigned cred_w = $clog2(`MD_OUT_CREDITS + 1);

    md_exec_t          ex;
    logic              wr_en;
    logic [31:0]       quot;
    logic [31:0]       rem;
    logic [31:0]       word;
    md_rsp_t           rbuf [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic [cred_w-1:0] credits;
    logic              send;

    // the done pulses never coincide
    assign ex    = mul_done ? mul_res : div_res;
    assign wr_en = mul_done | div_done;
    assign quot  = ex.val[31:0];
    assign rem   = ex.val[63:32];

    always_comb begin
        case (ex.op)
            op_mul:                      word = ex.val[31:0];
            op_mulh, op_mulhsu, op_mulhu: word = ex.val[63:32];
            op_div, op_divu: begin
                word = (ex.neg_quot && !ex.special) ? (~quot + 32'd1) : quot;
            end
            default: begin
                word = (ex.neg_rem && !ex.special) ? (~rem + 32'd1) : rem;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            rbuf[wr_ptr] <= '{tag: ex.tag, result: word};
        end
    end

    assign send         = (count != 2'd0) && (credits != '0);
    assign rsp_valid    = send;
    assign rsp          = rbuf[rd_ptr];
    assign result_ready = (count != 2'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
            credits <= cred_w'(`MD_OUT_CREDITS);
        end else begin
            if (wr_en) begin
                wr_ptr <= ~wr_ptr;
            end
            if (send) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({wr_en, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // spend one per response, regain one per returned credit
            case ({send, rsp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/md_unit.sv ====
// rv32m multiply divide unit
`timescale 1ns/1ns
`default_nettype none

module md_unit
    import md_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    req_valid,
    input  md_req_t req,
    output logic    req_credit,
    output logic    rsp_valid,
    output md_rsp_t rsp,
    input  logic    rsp_credit
);

    logic      head_valid;
    md_req_t   head;
    logic      head_take;
    logic      result_ready;
    md_issue_t issue;
    logic      mul_start;
    logic      div_start;
    logic      mul_done;
    logic      div_done;
    md_exec_t  mul_res;
    md_exec_t  div_res;

    md_in_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .head_valid (head_valid),
        .head       (head),
        .head_take  (head_take)
    );

    md_operand_prep u_prep (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head         (head),
        .head_take    (head_take),
        .result_ready (result_ready),
        .mul_done     (mul_done),
        .div_done     (div_done),
        .issue        (issue),
        .mul_start    (mul_start),
        .div_start    (div_start)
    );

    md_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .div_start (div_start),
        .issue     (issue),
        .div_done  (div_done),
        .div_res   (div_res)
    );

    md_multiplier u_mul (
        .clk       (clk),
        .rst       (rst),
        .mul_start (mul_start),
        .issue     (issue),
        .mul_done  (mul_done),
        .mul_res   (mul_res)
    );

    md_result_stage u_result (
        .clk          (clk),
        .rst          (rst),
        .mul_done     (mul_done),
        .mul_res      (mul_res),
        .div_done     (div_done),
        .div_res      (div_res),
        .result_ready (result_ready),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .rsp_credit   (rsp_credit)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the md_unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module md_unit_tb -f build.f \
    --Mdir obj_dir -o md_unit_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/md_unit_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
exit 1
